// ==== led_pkg.sv ====
package led_pkg;

    // Chain geometry
    localparam int num_drivers        = 30;
    localparam int conf_bits          = 48;
    localparam int gs_bits            = 48;
    localparam int groups_per_segment = 9;
    localparam int segments_per_slice = 8;

    // GCLK count per segment
    // Terminal value of the segment counter, so the LATGS pause cycle is included
    localparam int segment_cycles = 512;

    // 512 - (9 * 48 + 8) SCLK-free cycles that open every segment
    localparam int blank_cycles = 72;

    // LAT widths in SCLK units
    localparam int lat_fcwrten = 15;
    localparam int lat_wrtfc   = 5;
    localparam int lat_wrtgs   = 1;
    localparam int lat_latgs   = 3;

    // Idle enable periods after WRTFC
    localparam int wrtfc_wait = 5;

    // clk cycles per enable strobe
    localparam int clk_div = 4;

    // Words per slice, one word per SCLK data bit
    localparam int slice_words = groups_per_segment * gs_bits * segments_per_slice;

    // One bit per driver SIN line
    typedef logic [num_drivers-1:0] sin_word_t;
    typedef logic [conf_bits-1:0]   conf_word_t;
    typedef logic [11:0]            slice_addr_t;

    // Function-control word loaded at boot
    localparam conf_word_t conf_default = 48'h0040_2C80_1E7F;

    // Driver controller states
    typedef enum logic [3:0] {
        stall,
        prepare_config,
        configure,
        wrtfc_timing,
        stream,
        wait_slice
    } drv_state_t;

    // Pins of the shared driver clock group
    typedef struct packed {
        logic      sclk;
        logic      gclk;
        logic      lat;
        sin_word_t sin;
    } driver_pins_t;

    // Host write port of the slice buffer
    typedef struct packed {
        logic        valid;
        slice_addr_t addr;
        sin_word_t   data;
    } host_write_t;

endpackage

// ==== clk_enable_gen.sv ====
`timescale 1ns/1ps

module clk_enable_gen (
    input  logic clk,
    input  logic nrst,
    output logic clk_enable
);

    // Phase within one enable period
    logic [$clog2(led_pkg::clk_div)-1:0] div_cnt;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            div_cnt    <= '0;
            clk_enable <= 1'b0;
        end else begin
            // Strobe for one clk cycle each time the counter wraps
            if (div_cnt == led_pkg::clk_div - 1) begin
                div_cnt    <= '0;
                clk_enable <= 1'b1;
            end else begin
                div_cnt    <= div_cnt + 1'b1;
                clk_enable <= 1'b0;
            end
        end
    end

endmodule

// ==== driver_config_reg.sv ====
`timescale 1ns/1ps

module driver_config_reg (
    input  logic                clk,
    input  logic                nrst,
    input  logic                clk_enable,
    input  logic                conf_write,
    input  led_pkg::conf_word_t conf_word,
    output led_pkg::conf_word_t serialized_conf,
    output logic                conf_request
);

    // Function-control word shifted out by the controller
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            // Boot value so the chain comes up configured
            serialized_conf <= led_pkg::conf_default;
        end else if (conf_write) begin
            serialized_conf <= conf_word;
        end
    end

    // Request flag
    // Set at boot and on every host write
    // Held until the next enabled edge, where the controller samples it once
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            conf_request <= 1'b1;
        end else if (conf_write) begin
            // A write on an enabled cycle wins and is seen on the following strobe
            conf_request <= 1'b1;
        end else if (clk_enable) begin
            conf_request <= 1'b0;
        end
    end

endmodule

// ==== slice_buffer.sv ====
`timescale 1ns/1ps

module slice_buffer (
    input  logic                 clk,
    input  logic                 nrst,
    input  led_pkg::host_write_t host_wr,
    input  logic                 driver_ready,
    input  logic                 column_ready,
    output led_pkg::sin_word_t   framebuffer_dat
);

    // One slice of grayscale words, in shift order
    led_pkg::sin_word_t mem [led_pkg::slice_words];

    // Next word handed to the controller
    led_pkg::slice_addr_t rd_ptr;

    // Segments finished in the current slice
    logic [$clog2(led_pkg::segments_per_slice)-1:0] col_cnt;

    // Edge detect on column_ready, which spans a whole enable period
    logic column_ready_q;
    logic column_rise;

    // Aborted slice, flagged by driver_ready and column_ready together
    logic rewind;

    assign column_rise = column_ready & ~column_ready_q;
    assign rewind      = driver_ready & column_ready;

    // Host write port
    always_ff @(posedge clk) begin
        if (host_wr.valid && (host_wr.addr < led_pkg::slice_words)) begin
            mem[host_wr.addr] <= host_wr.data;
        end
    end

    // Registered read of the current pointer
    // Settles one clk after the pointer moves, well ahead of the next strobe
    always_ff @(posedge clk) begin
        framebuffer_dat <= mem[rd_ptr];
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            column_ready_q <= 1'b0;
        end else begin
            column_ready_q <= column_ready;
        end
    end

    // Read pointer and segment count
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_ptr  <= '0;
            col_cnt <= '0;
        end else if (rewind) begin
            // Controller left the slice early, restart at the first word
            rd_ptr  <= '0;
            col_cnt <= '0;
        end else if (column_rise) begin
            // End of the eighth segment wraps the slice
            if (col_cnt == led_pkg::segments_per_slice - 1) begin
                rd_ptr  <= '0;
                col_cnt <= '0;
            end else begin
                col_cnt <= col_cnt + 1'b1;
            end
        end else if (driver_ready) begin
            // Word taken on this strobe, step to the next one
            if (rd_ptr == led_pkg::slice_words - 1) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== driver_controller.sv ====
`timescale 1ns/1ps

module driver_controller (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  clk_enable,
    input  led_pkg::sin_word_t    framebuffer_dat,
    input  led_pkg::conf_word_t   serialized_conf,
    input  logic                  new_configuration_ready,
    input  logic                  position_sync,
    output led_pkg::driver_pins_t pins,
    output logic                  column_ready,
    output logic                  driver_ready
);

    led_pkg::drv_state_t state;

    // Cycle count inside prepare_config, configure and wrtfc_timing
    logic [$clog2(led_pkg::conf_bits+1)-1:0] state_cnt;
    // GCLK position in the segment, 0 is the pause after LATGS
    logic [$clog2(led_pkg::segment_cycles+1)-1:0] seg_cnt;
    // Bit within a group, 48 is the slot after WRTGS
    logic [$clog2(led_pkg::gs_bits+1)-1:0] bit_cnt;
    // Segment index inside the slice
    logic [$clog2(led_pkg::segments_per_slice)-1:0] mux_cnt;
    // GCLK still showing the last segment in wait_slice
    logic gclk_run;

    logic data_slot;
    logic abort;
    logic sclk_gate;
    logic gclk_gate;
    logic lat_next;
    led_pkg::sin_word_t sin_next;

    // Pin registers, updated on enabled edges
    logic lat_q;
    led_pkg::sin_word_t sin_q;

    // Strobe that computes a grayscale bit, shifted on the following strobe
    assign data_slot = (state == led_pkg::stream)
                       && (seg_cnt >= led_pkg::blank_cycles)
                       && (bit_cnt != led_pkg::gs_bits);

    // Host reconfiguration in the middle of a slice
    assign abort = clk_enable && (state == led_pkg::stream) && new_configuration_ready;

    // FSM and counters, all on enabled edges
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= led_pkg::stall;
            state_cnt <= '0;
            seg_cnt   <= '0;
            bit_cnt   <= '0;
            mux_cnt   <= '0;
            gclk_run  <= 1'b0;
        end else if (clk_enable) begin
            if (new_configuration_ready) begin
                // New word from the host restarts the whole sequence
                state     <= led_pkg::prepare_config;
                state_cnt <= '0;
                seg_cnt   <= '0;
                bit_cnt   <= '0;
                mux_cnt   <= '0;
                gclk_run  <= 1'b0;
            end else begin
                case (state)
                    led_pkg::stall: begin
                        state_cnt <= '0;
                    end

                    led_pkg::prepare_config: begin
                        // FCWRTEN
                        if (state_cnt == led_pkg::lat_fcwrten - 1) begin
                            state     <= led_pkg::configure;
                            state_cnt <= '0;
                        end else begin
                            state_cnt <= state_cnt + 1'b1;
                        end
                    end

                    led_pkg::configure: begin
                        // Last FCWRTEN edge, then the 48 config bits
                        if (state_cnt == led_pkg::conf_bits) begin
                            state     <= led_pkg::wrtfc_timing;
                            state_cnt <= '0;
                        end else begin
                            state_cnt <= state_cnt + 1'b1;
                        end
                    end

                    led_pkg::wrtfc_timing: begin
                        if (state_cnt == led_pkg::wrtfc_wait) begin
                            state     <= led_pkg::wait_slice;
                            state_cnt <= '0;
                        end else begin
                            state_cnt <= state_cnt + 1'b1;
                        end
                    end

                    led_pkg::wait_slice: begin
                        if (position_sync) begin
                            // Slice starts on a fresh segment
                            state    <= led_pkg::stream;
                            seg_cnt  <= '0;
                            bit_cnt  <= '0;
                            mux_cnt  <= '0;
                            gclk_run <= 1'b1;
                        end else if (gclk_run) begin
                            // Finish displaying the last latched segment
                            if (seg_cnt == led_pkg::segment_cycles) begin
                                seg_cnt  <= '0;
                                gclk_run <= 1'b0;
                            end else begin
                                seg_cnt <= seg_cnt + 1'b1;
                            end
                        end
                    end

                    led_pkg::stream: begin
                        if (seg_cnt == led_pkg::segment_cycles) begin
                            seg_cnt <= '0;
                            if (mux_cnt == led_pkg::segments_per_slice - 1) begin
                                mux_cnt <= '0;
                                state   <= led_pkg::wait_slice;
                            end else begin
                                mux_cnt <= mux_cnt + 1'b1;
                            end
                        end else begin
                            seg_cnt <= seg_cnt + 1'b1;
                        end
                        // 9 groups of 49 slots fill the rest of the segment exactly
                        if (seg_cnt >= led_pkg::blank_cycles) begin
                            if (bit_cnt == led_pkg::gs_bits) begin
                                bit_cnt <= '0;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end

                    default: begin
                        state     <= led_pkg::stall;
                        state_cnt <= '0;
                    end
                endcase
            end
        end
    end

    // Gates for the combinational driver clocks
    always_comb begin
        sclk_gate = 1'b0;
        gclk_gate = 1'b0;
        case (state)
            // 14 FCWRTEN edges here, the 15th on the first configure cycle
            led_pkg::prepare_config: sclk_gate = (state_cnt != '0);
            led_pkg::configure:      sclk_gate = 1'b1;
            // SCLK paused in blanking and for one slot after each WRTGS
            led_pkg::stream: begin
                sclk_gate = (bit_cnt != '0);
                gclk_gate = (seg_cnt != '0);
            end
            led_pkg::wait_slice:     gclk_gate = gclk_run && (seg_cnt != '0);
            // No SCLK while the drivers take the WRTFC
            default: begin
                sclk_gate = 1'b0;
                gclk_gate = 1'b0;
            end
        endcase
    end

    // LAT and SIN for the next SCLK edge
    always_comb begin
        lat_next = 1'b0;
        sin_next = '0;
        case (state)
            led_pkg::prepare_config: lat_next = 1'b1;

            led_pkg::configure: begin
                if (state_cnt < led_pkg::conf_bits) begin
                    // MSB first, same bit on every line
                    sin_next = {led_pkg::num_drivers{
                        serialized_conf[led_pkg::conf_bits - 1 - state_cnt]}};
                    // WRTFC over the last bits
                    lat_next = (state_cnt >= led_pkg::conf_bits - led_pkg::lat_wrtfc);
                end
            end

            led_pkg::stream: begin
                if (data_slot) begin
                    sin_next = framebuffer_dat;
                    // WRTGS closes each group
                    if (bit_cnt >= led_pkg::gs_bits - led_pkg::lat_wrtgs) begin
                        lat_next = 1'b1;
                    end
                    // LATGS widens the last one
                    if (seg_cnt >= led_pkg::segment_cycles - led_pkg::lat_latgs) begin
                        lat_next = 1'b1;
                    end
                end
            end

            default: begin
                lat_next = 1'b0;
                sin_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            lat_q <= 1'b0;
            sin_q <= '0;
        end else if (clk_enable) begin
            lat_q <= lat_next;
            sin_q <= sin_next;
        end
    end

    always_comb begin
        pins.sclk = clk_enable & sclk_gate;
        pins.gclk = clk_enable & gclk_gate;
        pins.lat  = lat_q;
        pins.sin  = sin_q;
    end

    // High for one enable period at each segment end, or one clk on abort
    assign column_ready = ((state == led_pkg::stream)
                           && (seg_cnt == led_pkg::segment_cycles)) || abort;

    // Word taken on this strobe, or rewind request together with column_ready
    assign driver_ready = (clk_enable && data_slot) || abort;

endmodule

// ==== led_driver_top.sv ====
`timescale 1ns/1ps

module led_driver_top (
    input  logic                  clk,
    input  logic                  nrst,
    input  led_pkg::host_write_t  host_wr,
    input  logic                  conf_write,
    input  led_pkg::conf_word_t   conf_word,
    input  logic                  position_sync,
    output led_pkg::driver_pins_t drv,
    output logic                  column_ready
);

    logic                clk_enable;
    logic                conf_request;
    logic                driver_ready;
    led_pkg::conf_word_t serialized_conf;
    led_pkg::sin_word_t  framebuffer_dat;

    // Pace of SCLK and GCLK
    clk_enable_gen clk_enable_gen_i (
        .clk        (clk),
        .nrst       (nrst),
        .clk_enable (clk_enable)
    );

    // Function-control word from the host
    driver_config_reg driver_config_reg_i (
        .clk             (clk),
        .nrst            (nrst),
        .clk_enable      (clk_enable),
        .conf_write      (conf_write),
        .conf_word       (conf_word),
        .serialized_conf (serialized_conf),
        .conf_request    (conf_request)
    );

    // Grayscale words of one slice
    slice_buffer slice_buffer_i (
        .clk             (clk),
        .nrst            (nrst),
        .host_wr         (host_wr),
        .driver_ready    (driver_ready),
        .column_ready    (column_ready),
        .framebuffer_dat (framebuffer_dat)
    );

    driver_controller driver_controller_i (
        .clk                     (clk),
        .nrst                    (nrst),
        .clk_enable              (clk_enable),
        .framebuffer_dat         (framebuffer_dat),
        .serialized_conf         (serialized_conf),
        .new_configuration_ready (conf_request),
        .position_sync           (position_sync),
        .pins                    (drv),
        .column_ready            (column_ready),
        .driver_ready            (driver_ready)
    );

endmodule

// ==== led_driver_checker.sv ====
`timescale 1ns/1ps

module led_driver_checker (
    input logic                  clk,
    input logic                  nrst,
    input led_pkg::driver_pins_t pins,
    input logic                  column_ready,
    input logic                  conf_write,
    input logic                  position_sync
);

    typedef enum logic [1:0] {ph_idle, ph_config, ph_stream} phase_t;

    // Data bits shifted per segment
    localparam int seg_words = led_pkg::groups_per_segment * led_pkg::gs_bits;

    phase_t phase;
    int     errors;
    int     configs_done;
    int     slices_done;
    int     segment_ends;
    int     edge_idx;
    int     seg_idx;
    int     cr_len;
    int     gclk_cnt;
    logic   cfg_pending;
    logic   in_reset;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %0t ns %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("ERROR %0t ns %s", $time, what);
    endtask

    // FCWRTEN edges, then the word MSB first on all lines with WRTFC at the end
    task automatic config_edge();
        logic bit_val;
        if (edge_idx < led_pkg::lat_fcwrten) begin
            check_value("drv.lat", 1'b1, pins.lat);
        end else begin
            bit_val = tb_led_driver.exp_conf[led_pkg::conf_bits - 1
                                             - (edge_idx - led_pkg::lat_fcwrten)];
            check_value("drv.sin", {led_pkg::num_drivers{bit_val}}, pins.sin);
            check_value("drv.lat", edge_idx >= led_pkg::lat_fcwrten + led_pkg::conf_bits
                                               - led_pkg::lat_wrtfc, pins.lat);
        end
        edge_idx++;
        if (edge_idx == led_pkg::lat_fcwrten + led_pkg::conf_bits) begin
            phase = ph_idle;
            configs_done++;
            // No GCLK run-out follows a configuration
            gclk_cnt = led_pkg::segment_cycles;
        end
    endtask

    // WRTGS on the last bit of a group, LATGS on the last three of the ninth
    task automatic stream_edge();
        int grp;
        int bit_pos;
        grp     = edge_idx / led_pkg::gs_bits;
        bit_pos = edge_idx % led_pkg::gs_bits;
        if (edge_idx >= seg_words) begin
            report("SCLK pulse beyond the data bits of a segment");
        end else begin
            check_value("drv.sin", tb_led_driver.slice_mem[seg_idx * seg_words + edge_idx],
                        pins.sin);
            check_value("drv.lat", (bit_pos == led_pkg::gs_bits - led_pkg::lat_wrtgs)
                        || (grp == led_pkg::groups_per_segment - 1
                            && bit_pos >= led_pkg::gs_bits - led_pkg::lat_latgs), pins.lat);
        end
        edge_idx++;
    endtask

    task automatic column_end();
        if (phase != ph_stream) begin
            report("column_ready pulse outside a slice");
        end else if (cr_len < led_pkg::clk_div) begin
            // Short pulse is the abort of a slice by a new configuration
            if (!cfg_pending) report("slice aborted with no configuration write");
            phase    = ph_idle;
            gclk_cnt = 0;
        end else begin
            // One enable period per segment end
            check_value("column_ready pulse width", led_pkg::clk_div, cr_len);
            check_value("data bits per segment", seg_words, edge_idx);
            check_value("drv.gclk pulses per segment", led_pkg::segment_cycles, gclk_cnt);
            segment_ends++;
            seg_idx++;
            edge_idx = 0;
            gclk_cnt = 0;
            if (seg_idx == led_pkg::segments_per_slice) begin
                phase = ph_idle;
                slices_done++;
            end
        end
    endtask

    // Sampled mid-cycle away from the pin register updates
    always @(negedge clk) begin
        if (!nrst) begin
            check_value("drv", '0, pins);
            check_value("column_ready", 1'b0, column_ready);
            phase       = ph_idle;
            cfg_pending = 1'b1;
            in_reset    = 1'b1;
            edge_idx    = 0;
            seg_idx     = 0;
            cr_len      = 0;
            gclk_cnt    = 0;
        end else begin
            if (in_reset) begin
                // First cycle out of reset, before any enable strobe
                check_value("drv", '0, pins);
                check_value("column_ready", 1'b0, column_ready);
                in_reset = 1'b0;
            end
            if (conf_write) cfg_pending = 1'b1;
            if (pins.sclk) begin
                // First FCWRTEN edge opens a configuration
                if (phase == ph_idle && cfg_pending) begin
                    phase       = ph_config;
                    cfg_pending = 1'b0;
                    edge_idx    = 0;
                end
                case (phase)
                    ph_config: config_edge();
                    ph_stream: stream_edge();
                    default:   report("SCLK pulse with no configuration or slice in progress");
                endcase
            end
            if (pins.gclk) begin
                gclk_cnt++;
                if (phase == ph_config) begin
                    report("GCLK pulse during configuration");
                end else if (phase == ph_idle && gclk_cnt > led_pkg::segment_cycles) begin
                    report("GCLK pulse outside a slice and its run-out segment");
                end
            end
            if (column_ready) begin
                cr_len++;
            end else if (cr_len > 0) begin
                column_end();
                cr_len = 0;
            end
            // Slice start is held open while position_sync is high
            if (position_sync && !cfg_pending && (phase == ph_idle
                    || (phase == ph_stream && seg_idx == 0 && edge_idx == 0))) begin
                phase    = ph_stream;
                seg_idx  = 0;
                edge_idx = 0;
                gclk_cnt = 0;
            end
        end
    end

endmodule

// ==== tb_led_driver.sv ====
`timescale 1ns/1ps

module tb_led_driver;

    // Run length, used only by the watchdog
    localparam int num_configs = 3;
    localparam int num_slices  = 4;
    localparam longint watchdog_ns =
        (longint'(num_configs) * 80 + num_slices * 8 * 513 + 2000) * led_pkg::clk_div * 20;

    logic                  clk;
    logic                  nrst;
    led_pkg::host_write_t  host_wr;
    logic                  conf_write;
    led_pkg::conf_word_t   conf_word;
    logic                  position_sync;
    led_pkg::driver_pins_t drv;
    logic                  column_ready;

    // Reference model, read by the checker
    led_pkg::conf_word_t exp_conf;
    led_pkg::sin_word_t  slice_mem [led_pkg::slice_words];

    integer seed;
    int     tb_errors;
    int     slices_expected;
    int     segs;
    int     base;

    led_driver_top dut_i (
        .clk           (clk),
        .nrst          (nrst),
        .host_wr       (host_wr),
        .conf_write    (conf_write),
        .conf_word     (conf_word),
        .position_sync (position_sync),
        .drv           (drv),
        .column_ready  (column_ready)
    );

    led_driver_checker checker_i (
        .clk           (clk),
        .nrst          (nrst),
        .pins          (drv),
        .column_ready  (column_ready),
        .conf_write    (conf_write),
        .position_sync (position_sync)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Whole enable periods, ending 2 ns past a rising edge
    task automatic wait_periods(input int n);
        repeat (n * led_pkg::clk_div) @(posedge clk);
        #2;
    endtask

    // Fill the slice buffer and the model with random words
    task automatic load_slice();
        led_pkg::sin_word_t word;
        for (int a = 0; a < led_pkg::slice_words; a++) begin
            word = $random(seed);
            @(posedge clk);
            #2;
            host_wr.valid = 1'b1;
            host_wr.addr  = led_pkg::slice_addr_t'(a);
            host_wr.data  = word;
            slice_mem[a]  = word;
        end
        @(posedge clk);
        #2;
        host_wr.valid = 1'b0;
    endtask

    // One-cycle conf_write with a fresh random word
    task automatic write_config();
        led_pkg::conf_word_t word;
        word[47:32] = $random(seed);
        word[31:0]  = $random(seed);
        @(posedge clk);
        #2;
        conf_word  = word;
        conf_write = 1'b1;
        exp_conf   = word;
        @(posedge clk);
        #2;
        conf_write = 1'b0;
    endtask

    // WRTFC wait plus a random gap, then position_sync over one enable period
    task automatic start_slice();
        int gap;
        gap = {$random(seed)} % 32;
        wait_periods(led_pkg::wrtfc_wait + 2 + gap);
        position_sync = 1'b1;
        repeat (led_pkg::clk_div) @(posedge clk);
        #2;
        position_sync = 1'b0;
    endtask

    task automatic run_slice();
        start_slice();
        slices_expected++;
        wait (checker_i.slices_done == slices_expected);
    endtask

    task automatic finish_run();
        $display("Errors: checker %0d, testbench %0d", checker_i.errors, tb_errors);
        if (checker_i.errors + tb_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        seed            = 32'h8dcf7aea;
        tb_errors       = 0;
        slices_expected = 0;
        nrst            = 1'b0;
        host_wr         = '0;
        conf_write      = 1'b0;
        conf_word       = '0;
        position_sync   = 1'b0;
        exp_conf        = led_pkg::conf_default;
        repeat (3) @(posedge clk);
        #2;
        nrst = 1'b1;

        // Boot configuration runs while the first slice is loaded
        load_slice();
        wait (checker_i.configs_done == 1);
        run_slice();

        // New data also covers the GCLK run-out after the slice
        load_slice();
        write_config();
        wait (checker_i.configs_done == 2);
        run_slice();

        // Cut a slice in the middle of a segment
        start_slice();
        segs = 1 + {$random(seed)} % 5;
        base = checker_i.segment_ends;
        wait (checker_i.segment_ends == base + segs);
        wait_periods(100 + {$random(seed)} % 200);
        write_config();
        wait (checker_i.configs_done == 3);

        // Streaming only restarts on a new position_sync
        run_slice();
        wait_periods(led_pkg::segment_cycles + 8);
        finish_run();
    end

    initial begin
        #(watchdog_ns);
        tb_errors++;
        $display("ERROR %0t ns watchdog expired before the test sequence finished", $time);
        finish_run();
    end

endmodule

// ==== flist.f ====
led_pkg.sv
clk_enable_gen.sv
driver_config_reg.sv
slice_buffer.sv
driver_controller.sv
led_driver_top.sv
led_driver_checker.sv
tb_led_driver.sv

// ==== Bender.yml ====
package:
  name: led_driver

sources:
  - files:
      - led_pkg.sv
      - clk_enable_gen.sv
      - driver_config_reg.sv
      - slice_buffer.sv
      - driver_controller.sv
      - led_driver_top.sv
  - target: test
    files:
      - led_driver_checker.sv
      - tb_led_driver.sv
